//--- test/rf_exec_golden.txt
# kind offset wdata expected_rdata resp (0 OKAY, 2 SLVERR)
# W lines check bresp only, R lines check rdata and rresp
W 04 F0F01234 00000000 0
W 00 00000018 00000000 0
W 04 00000013 00000000 0
W 00 00000028 00000000 0
W 04 5A5AA5A5 00000000 0
W 00 000001F8 00000000 0
R 84 00000000 F0F01234 0
R 88 00000000 00000013 0
R FC 00000000 5A5AA5A5 0
W 00 00008230 00000000 0
R 08 00000000 F0F01247 0
W 00 00008241 00000000 0
W 00 00008252 00000000 0
W 00 00008263 00000000 0
W 00 00008274 00000000 0
W 00 00008285 00000000 0
W 00 00008296 00000000 0
W 00 000082A7 00000000 0
R 08 00000000 00000001 0
R 8C 00000000 F0F01247 0
R 90 00000000 F0F01221 0
R 94 00000000 00000010 0
R 98 00000000 F0F01237 0
R 9C 00000000 F0F01227 0
R A0 00000000 91A00000 0
R A4 00000000 00001E1E 0
R A8 00000000 00000001 0
W 00 00008200 00000000 0
R 08 00000000 F0F01247 0
R 80 00000000 00000000 0
W 08 12345678 00000000 2
W 0C 00000001 00000000 2
W 84 DEADBEEF 00000000 2
R 84 00000000 F0F01234 0
R 10 00000000 00000000 2
R 0C 00000000 00000000 0

//--- sources.f
+incdir+source
source/rf_types_pkg.sv
source/axil_types_pkg.sv
source/int_alu.sv
source/reg_file.sv
source/exec_ctrl.sv
source/axil_port.sv
source/rf_exec_top.sv
test/rf_exec_checker.sv
test/tb_rf_exec.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rf_exec \
  -f sources.f -o sim_rf_exec || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/sim_rf_exec)" || { printf '%s\n' "$out"; echo "Simulation aborted"; exit 1; }
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed" && exit 0 || exit 1

//--- test/tb_rf_exec.sv
// --------------------
// Testbench for the register-file slice
// Golden-file driven AXI4-Lite master
// --------------------
`timescale 1ns/1ps
`include "rf_cfg.svh"

module tb_rf_exec;

  import axil_types_pkg::*;

  localparam int          MAX_TXN = 64;
  localparam int          TIMEOUT = 200;
  localparam logic [31:0] SEED    = 32'h80c6e90a;

  logic                    clk_int;
  logic                    rst_ni;
  logic                    awvalid;
  logic                    awready;
  logic [`AXIL_ADDR_W-1:0] awaddr;
  logic                    wvalid;
  logic                    wready;
  logic [`RF_DATA_W-1:0]   wdata;
  logic [`RF_DATA_W/8-1:0] wstrb;
  logic                    bvalid;
  logic                    bready;
  axil_resp_e              bresp;
  logic                    arvalid;
  logic                    arready;
  logic [`AXIL_ADDR_W-1:0] araddr;
  logic                    rvalid;
  logic                    rready;
  logic [`RF_DATA_W-1:0]   rdata;
  axil_resp_e              rresp;

  // Golden transactions in file order
  logic [7:0]              txn_kind [MAX_TXN];
  logic [`AXIL_ADDR_W-1:0] txn_off  [MAX_TXN];
  logic [`RF_DATA_W-1:0]   txn_data [MAX_TXN];
  int                      num_txn;
  int                      errors;
  int                      chk_errors;
  int                      chk_count;
  logic [31:0]             rng;

  rf_exec_top rf_exec_top_inst (
    .clk_int   (clk_int),
    .rst_ni    (rst_ni),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  rf_exec_checker checker_inst (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .bvalid_i      (bvalid),
    .bready_i      (bready),
    .bresp_i       (bresp),
    .rvalid_i      (rvalid),
    .rready_i      (rready),
    .rdata_i       (rdata),
    .rresp_i       (rresp),
    .error_count_o (chk_errors),
    .check_count_o (chk_count)
  );

  // 100 ns period
  initial begin
    clk_int = 1'b0;
    forever #50 clk_int = ~clk_int;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ready three times out of four
  function automatic logic draw_ready();
    rng = xorshift32(rng);
    return (rng[1:0] != 2'b00);
  endfunction

  task automatic load_golden();
    int                      fd;
    int                      n;
    string                   line;
    logic [7:0]              kind;
    logic [`AXIL_ADDR_W-1:0] off;
    logic [`RF_DATA_W-1:0]   wd;
    logic [`RF_DATA_W-1:0]   ed;
    logic [1:0]              er;
    num_txn = 0;
    fd = $fopen("test/rf_exec_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file test/rf_exec_golden.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) > 0 && num_txn < MAX_TXN) begin
      n = $sscanf(line, "%c %h %h %h %h", kind, off, wd, ed, er);
      if (n == 5 && (kind == "W" || kind == "R")) begin
        txn_kind[num_txn] = kind;
        txn_off[num_txn]  = off;
        txn_data[num_txn] = wd;
        num_txn++;
      end
    end
    $fclose(fd);
  endtask

  // Called just after a rising edge, returns just after one
  task automatic write_reg(input logic [`AXIL_ADDR_W-1:0] addr,
                           input logic [`RF_DATA_W-1:0]   data);
    int waited;
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= '1;
    waited = 0;
    @(negedge clk_int);
    // AW and W go in on the same edge
    while (!(awready && wready) && waited < TIMEOUT) begin
      @(negedge clk_int);
      waited++;
    end
    @(posedge clk_int);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (waited >= TIMEOUT) begin
      $display("Timeout: write to offset %h was never accepted", addr);
      errors++;
      return;
    end
    waited = 0;
    @(negedge clk_int);
    while (!bvalid && waited < TIMEOUT) begin
      @(negedge clk_int);
      waited++;
    end
    if (waited >= TIMEOUT) begin
      $display("Timeout: no write response for offset %h", addr);
      errors++;
    end
    @(posedge clk_int);
  endtask

  task automatic read_reg(input logic [`AXIL_ADDR_W-1:0] addr);
    int waited;
    arvalid <= 1'b1;
    araddr  <= addr;
    waited = 0;
    @(negedge clk_int);
    while (!arready && waited < TIMEOUT) begin
      @(negedge clk_int);
      waited++;
    end
    @(posedge clk_int);
    arvalid <= 1'b0;
    if (waited >= TIMEOUT) begin
      $display("Timeout: read of offset %h was never accepted", addr);
      errors++;
      return;
    end
    rready <= draw_ready();
    waited = 0;
    @(negedge clk_int);
    // Random stalls on the read data channel
    while (!(rvalid && rready) && waited < TIMEOUT) begin
      @(posedge clk_int);
      rready <= draw_ready();
      @(negedge clk_int);
      waited++;
    end
    if (waited >= TIMEOUT) begin
      $display("Timeout: no read data for offset %h", addr);
      errors++;
    end
    @(posedge clk_int);
    rready <= 1'b0;
  endtask

  initial begin
    rst_ni  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b1;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    rng     = SEED;
    errors  = 0;
    load_golden();
    repeat (2) @(posedge clk_int);
    rst_ni <= 1'b1;
    for (int i = 0; i < num_txn; i++) begin
      if (txn_kind[i] == "W") begin
        write_reg(txn_off[i], txn_data[i]);
      end else begin
        read_reg(txn_off[i]);
      end
    end
    repeat (2) @(posedge clk_int);
    if (num_txn == 0 || chk_count != num_txn) begin
      $display("Only %0d of %0d golden transactions reached the checker", chk_count, num_txn);
      errors++;
    end
    $display("Bus errors: %0d, data errors: %0d, transactions checked: %0d",
             errors, chk_errors, chk_count);
    if (errors == 0 && chk_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- test/rf_exec_checker.sv
// --------------------
// Response checker for the register-file slice
// Matches each B and R handshake to the golden list
// --------------------
`timescale 1ns/1ps
`include "rf_cfg.svh"

module rf_exec_checker (
  input  logic                       clk_int,
  input  logic                       rst_ni,
  input  logic                       bvalid_i,
  input  logic                       bready_i,
  input  axil_types_pkg::axil_resp_e bresp_i,
  input  logic                       rvalid_i,
  input  logic                       rready_i,
  input  logic [`RF_DATA_W-1:0]      rdata_i,
  input  axil_types_pkg::axil_resp_e rresp_i,
  output int                         error_count_o,
  output int                         check_count_o
);

  localparam int MAX_TXN = 64;

  // Expectations in file order
  logic [7:0]              exp_kind [MAX_TXN];
  logic [`AXIL_ADDR_W-1:0] exp_off  [MAX_TXN];
  logic [`RF_DATA_W-1:0]   exp_data [MAX_TXN];
  logic [1:0]              exp_resp [MAX_TXN];
  int                      num_txn = 0;
  int                      idx     = 0;
  int                      err_cnt = 0;

  task automatic load_golden();
    int                      fd;
    int                      n;
    string                   line;
    logic [7:0]              kind;
    logic [`AXIL_ADDR_W-1:0] off;
    logic [`RF_DATA_W-1:0]   wd;
    logic [`RF_DATA_W-1:0]   ed;
    logic [1:0]              er;
    fd = $fopen("test/rf_exec_golden.txt", "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) > 0 && num_txn < MAX_TXN) begin
      n = $sscanf(line, "%c %h %h %h %h", kind, off, wd, ed, er);
      // Comment lines never start with W or R
      if (n == 5 && (kind == "W" || kind == "R")) begin
        exp_kind[num_txn] = kind;
        exp_off[num_txn]  = off;
        exp_data[num_txn] = ed;
        exp_resp[num_txn] = er;
        num_txn++;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    load_golden();
  end

  // Valid and ready seen mid-cycle mean a transfer on the next edge
  always @(negedge clk_int) begin
    if (rst_ni && bvalid_i && bready_i) begin
      if (idx >= num_txn || exp_kind[idx] != "W") begin
        $display("Unexpected write response at %0d ns with no golden write left", $time);
        err_cnt++;
      end else if (bresp_i !== exp_resp[idx]) begin
        $display("Error at %0d ns: write to %h gave bresp %0d, expected %0d",
                 $time, exp_off[idx], bresp_i, exp_resp[idx]);
        err_cnt++;
      end
      idx++;
    end
    if (rst_ni && rvalid_i && rready_i) begin
      if (idx >= num_txn || exp_kind[idx] != "R") begin
        $display("Unexpected read data at %0d ns with no golden read left", $time);
        err_cnt++;
      end else if (rdata_i !== exp_data[idx] || rresp_i !== exp_resp[idx]) begin
        $display("Error at %0d ns: read of %h gave %h/%0d, expected %h/%0d",
                 $time, exp_off[idx], rdata_i, rresp_i, exp_data[idx], exp_resp[idx]);
        err_cnt++;
      end
      idx++;
    end
  end

  assign error_count_o = err_cnt;
  assign check_count_o = idx;

endmodule

//--- source/rf_exec_top.sv
// --------------------
// Register-file execution slice
// Bus port, control FSM, register file and ALU
// --------------------
`timescale 1ns/1ps
`include "rf_cfg.svh"

module rf_exec_top (
  input  logic                       clk_int,
  input  logic                       rst_ni,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`AXIL_ADDR_W-1:0]    awaddr_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [`RF_DATA_W-1:0]      wdata_i,
  input  logic [`RF_DATA_W/8-1:0]    wstrb_i,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  output axil_types_pkg::axil_resp_e bresp_o,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  input  logic [`AXIL_ADDR_W-1:0]    araddr_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [`RF_DATA_W-1:0]      rdata_o,
  output axil_types_pkg::axil_resp_e rresp_o
);

  import rf_types_pkg::*;

  // Port to control
  logic     cmd_valid;
  logic     cmd_done;
  alu_op_e  cmd_op;
  rf_addr_t cmd_rd;
  rf_addr_t cmd_rs1;
  rf_addr_t cmd_rs2;
  rf_data_t imm;
  logic     rb_valid;
  logic     rb_done;
  rf_addr_t rb_addr;
  rf_data_t rb_data;
  rf_data_t result;
  logic     busy;
  // Control to register file and ALU
  rf_addr_t raddr_a;
  rf_addr_t raddr_b;
  rf_data_t rdata_a;
  rf_data_t rdata_b;
  alu_op_e  alu_op;
  rf_data_t alu_a;
  rf_data_t alu_b;
  rf_data_t alu_res;
  rf_addr_t waddr;
  rf_data_t wdata;
  logic     we;

  axil_port axil_port_inst (
    .clk_int     (clk_int),
    .rst_ni      (rst_ni),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .awaddr_i    (awaddr_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .bresp_o     (bresp_o),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .araddr_i    (araddr_i),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .cmd_valid_o (cmd_valid),
    .cmd_op_o    (cmd_op),
    .cmd_rd_o    (cmd_rd),
    .cmd_rs1_o   (cmd_rs1),
    .cmd_rs2_o   (cmd_rs2),
    .imm_o       (imm),
    .cmd_done_i  (cmd_done),
    .rb_valid_o  (rb_valid),
    .rb_addr_o   (rb_addr),
    .rb_data_i   (rb_data),
    .rb_done_i   (rb_done),
    .result_i    (result),
    .busy_i      (busy)
  );

  exec_ctrl exec_ctrl_inst (
    .clk_int     (clk_int),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid),
    .cmd_op_i    (cmd_op),
    .cmd_rd_i    (cmd_rd),
    .cmd_rs1_i   (cmd_rs1),
    .cmd_rs2_i   (cmd_rs2),
    .imm_i       (imm),
    .cmd_done_o  (cmd_done),
    .rb_valid_i  (rb_valid),
    .rb_addr_i   (rb_addr),
    .rb_data_o   (rb_data),
    .rb_done_o   (rb_done),
    .busy_o      (busy),
    .result_o    (result),
    .raddr_a_o   (raddr_a),
    .raddr_b_o   (raddr_b),
    .rdata_a_i   (rdata_a),
    .rdata_b_i   (rdata_b),
    .alu_op_o    (alu_op),
    .alu_a_o     (alu_a),
    .alu_b_o     (alu_b),
    .alu_res_i   (alu_res),
    .waddr_o     (waddr),
    .wdata_o     (wdata),
    .we_o        (we)
  );

  reg_file reg_file_inst (
    .clk_int   (clk_int),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (raddr_b),
    .rdata_b_o (rdata_b),
    .waddr_i   (waddr),
    .wdata_i   (wdata),
    .we_i      (we)
  );

  int_alu int_alu_inst (
    .op_i  (alu_op),
    .a_i   (alu_a),
    .b_i   (alu_b),
    .res_o (alu_res)
  );

endmodule

//--- source/axil_port.sv
// --------------------
// AXI4-Lite slave port
// Turns bus writes and reads into command,
// immediate and readback requests
// --------------------
`timescale 1ns/1ps
`include "rf_cfg.svh"

module axil_port (
  input  logic                         clk_int,
  input  logic                         rst_ni,
  // Write address and data
  input  logic                         awvalid_i,
  output logic                         awready_o,
  input  logic [`AXIL_ADDR_W-1:0]      awaddr_i,
  input  logic                         wvalid_i,
  output logic                         wready_o,
  input  logic [`RF_DATA_W-1:0]        wdata_i,
  input  logic [`RF_DATA_W/8-1:0]      wstrb_i,
  // Write response
  output logic                         bvalid_o,
  input  logic                         bready_i,
  output axil_types_pkg::axil_resp_e   bresp_o,
  // Read address and data
  input  logic                         arvalid_i,
  output logic                         arready_o,
  input  logic [`AXIL_ADDR_W-1:0]      araddr_i,
  output logic                         rvalid_o,
  input  logic                         rready_i,
  output logic [`RF_DATA_W-1:0]        rdata_o,
  output axil_types_pkg::axil_resp_e   rresp_o,
  // Command toward control
  output logic                         cmd_valid_o,
  output rf_types_pkg::alu_op_e        cmd_op_o,
  output rf_types_pkg::rf_addr_t       cmd_rd_o,
  output rf_types_pkg::rf_addr_t       cmd_rs1_o,
  output rf_types_pkg::rf_addr_t       cmd_rs2_o,
  output rf_types_pkg::rf_data_t       imm_o,
  input  logic                         cmd_done_i,
  // Register readback
  output logic                         rb_valid_o,
  output rf_types_pkg::rf_addr_t       rb_addr_o,
  input  rf_types_pkg::rf_data_t       rb_data_i,
  input  logic                         rb_done_i,
  // Status from control
  input  rf_types_pkg::rf_data_t       result_i,
  input  logic                         busy_i
);

  import rf_types_pkg::*;
  import axil_types_pkg::*;

  logic       bvalid_q;
  logic       rvalid_q;
  logic       cmd_valid_q;
  logic       rb_valid_q;
  axil_resp_e bresp_q;
  axil_resp_e rresp_q;
  rf_data_t   rdata_q;
  rf_data_t   imm_q;
  alu_op_e    op_q;
  rf_addr_t   rd_q;
  rf_addr_t   rs1_q;
  rf_addr_t   rs2_q;
  rf_addr_t   rb_addr_q;
  logic       aw_is_cmd;
  logic       aw_is_imm;
  logic       ar_is_win;
  logic       wr_fire;
  logic       rd_fire;

  assign aw_is_cmd = (awaddr_i == OFF_CMD);
  assign aw_is_imm = (awaddr_i == OFF_IMM);
  // Window is the upper half, word aligned
  assign ar_is_win = araddr_i[`AXIL_ADDR_W-1] && (araddr_i[1:0] == 2'b00);

  // AW and W only together, one write in flight
  // CMD waits for the control FSM to go idle
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_q && !cmd_valid_q &&
                     !(aw_is_cmd && busy_i);
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;

  // One read in flight, bus side or readback
  assign arready_o = !rvalid_q && !rb_valid_q;
  assign rd_fire   = arvalid_i && arready_o;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q    <= 1'b0;
      cmd_valid_q <= 1'b0;
      rvalid_q    <= 1'b0;
      rb_valid_q  <= 1'b0;
    end else begin
      // CMD response held back until the command is taken
      if (wr_fire) begin
        cmd_valid_q <= aw_is_cmd;
        bvalid_q    <= !aw_is_cmd;
      end else if (cmd_done_i) begin
        cmd_valid_q <= 1'b0;
        bvalid_q    <= 1'b1;
      end else if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end
      // Window reads go through control first
      if (rd_fire) begin
        rb_valid_q <= ar_is_win;
        rvalid_q   <= !ar_is_win;
      end else if (rb_done_i) begin
        rb_valid_q <= 1'b0;
        rvalid_q   <= 1'b1;
      end else if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_int) begin
    if (wr_fire) begin
      bresp_q <= (aw_is_cmd || aw_is_imm) ? RESP_OKAY : RESP_SLVERR;
      // Command fields
      if (aw_is_cmd) begin
        op_q  <= alu_op_e'(wdata_i[3:0]);
        rd_q  <= wdata_i[8:4];
        rs1_q <= wdata_i[13:9];
        rs2_q <= wdata_i[18:14];
      end
      // Immediate honours byte strobes
      if (aw_is_imm) begin
        for (int b = 0; b < `RF_DATA_W/8; b++) begin
          if (wstrb_i[b]) begin
            imm_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
    if (rd_fire) begin
      rb_addr_q <= araddr_i[6:2];
      case (araddr_i)
        OFF_RESULT: begin
          rdata_q <= result_i;
          rresp_q <= RESP_OKAY;
        end
        OFF_STATUS: begin
          rdata_q <= rf_data_t'(busy_i);
          rresp_q <= RESP_OKAY;
        end
        default: begin
          rdata_q <= '0;
          rresp_q <= ar_is_win ? RESP_OKAY : RESP_SLVERR;
        end
      endcase
    end else if (rb_done_i) begin
      rdata_q <= rb_data_i;
    end
  end

  assign bvalid_o    = bvalid_q;
  assign bresp_o     = bresp_q;
  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign rresp_o     = rresp_q;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_op_o    = op_q;
  assign cmd_rd_o    = rd_q;
  assign cmd_rs1_o   = rs1_q;
  assign cmd_rs2_o   = rs2_q;
  assign imm_o       = imm_q;
  assign rb_valid_o  = rb_valid_q;
  assign rb_addr_o   = rb_addr_q;

endmodule

//--- source/exec_ctrl.sv
// --------------------
// Execution control FSM
// Sequences operand reads, ALU and write-back,
// and serves register readback
// --------------------
`timescale 1ns/1ps

module exec_ctrl (
  input  logic                   clk_int,
  input  logic                   rst_ni,
  // Command from the bus port
  input  logic                   cmd_valid_i,
  input  rf_types_pkg::alu_op_e  cmd_op_i,
  input  rf_types_pkg::rf_addr_t cmd_rd_i,
  input  rf_types_pkg::rf_addr_t cmd_rs1_i,
  input  rf_types_pkg::rf_addr_t cmd_rs2_i,
  input  rf_types_pkg::rf_data_t imm_i,
  output logic                   cmd_done_o,
  // Readback request
  input  logic                   rb_valid_i,
  input  rf_types_pkg::rf_addr_t rb_addr_i,
  output rf_types_pkg::rf_data_t rb_data_o,
  output logic                   rb_done_o,
  // Status
  output logic                   busy_o,
  output rf_types_pkg::rf_data_t result_o,
  // Register file read ports
  output rf_types_pkg::rf_addr_t raddr_a_o,
  output rf_types_pkg::rf_addr_t raddr_b_o,
  input  rf_types_pkg::rf_data_t rdata_a_i,
  input  rf_types_pkg::rf_data_t rdata_b_i,
  // ALU
  output rf_types_pkg::alu_op_e  alu_op_o,
  output rf_types_pkg::rf_data_t alu_a_o,
  output rf_types_pkg::rf_data_t alu_b_o,
  input  rf_types_pkg::rf_data_t alu_res_i,
  // Register file write port
  output rf_types_pkg::rf_addr_t waddr_o,
  output rf_types_pkg::rf_data_t wdata_o,
  output logic                   we_o
);

  import rf_types_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_COMMIT,
    ST_READBACK
  } state_e;

  state_e   state_q;
  state_e   state_d;
  rf_data_t result_q;
  rf_data_t exec_res;
  rf_addr_t waddr_q;
  logic     cmd_take;

  // Commands win over readback
  assign cmd_take = (state_q == ST_IDLE) && cmd_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          state_d = ST_EXEC;
        end else if (rb_valid_i) begin
          state_d = ST_READBACK;
        end
      end
      // Write enable cycle
      ST_EXEC:     state_d = ST_COMMIT;
      // Register file commits the sampled word
      ST_COMMIT:   state_d = ST_IDLE;
      ST_READBACK: state_d = ST_IDLE;
      default:     state_d = ST_IDLE;
    endcase
  end

  // LOADI skips the ALU
  assign exec_res = (cmd_op_i == ALU_LOADI) ? imm_i : alu_res_i;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_IDLE;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_take) begin
        result_q <= exec_res;
      end
    end
  end

  // Destination held for the write cycle
  always_ff @(posedge clk_int) begin
    if (cmd_take) begin
      waddr_q <= cmd_rd_i;
    end
  end

  // Port A serves readback in its own state
  assign raddr_a_o = (state_q == ST_READBACK) ? rb_addr_i : cmd_rs1_i;
  assign raddr_b_o = cmd_rs2_i;
  assign alu_op_o  = cmd_op_i;
  assign alu_a_o   = rdata_a_i;
  assign alu_b_o   = rdata_b_i;

  assign cmd_done_o = cmd_take;
  assign rb_done_o  = (state_q == ST_READBACK);
  assign rb_data_o  = rdata_a_i;
  assign busy_o     = (state_q != ST_IDLE);
  assign result_o   = result_q;

  // One write per command
  assign we_o    = (state_q == ST_EXEC);
  assign waddr_o = waddr_q;
  assign wdata_o = result_q;

endmodule

//--- source/reg_file.sv
// --------------------
// Integer register file
// Two read ports, one write port, zero register,
// write data sampled then committed a cycle later
// --------------------
`timescale 1ns/1ps
`include "rf_cfg.svh"

module reg_file (
  input  logic                   clk_int,
  input  logic                   rst_ni,
  // Read port A
  input  rf_types_pkg::rf_addr_t raddr_a_i,
  output rf_types_pkg::rf_data_t rdata_a_o,
  // Read port B
  input  rf_types_pkg::rf_addr_t raddr_b_i,
  output rf_types_pkg::rf_data_t rdata_b_o,
  // Write port
  input  rf_types_pkg::rf_addr_t waddr_i,
  input  rf_types_pkg::rf_data_t wdata_i,
  input  logic                   we_i
);

  import rf_types_pkg::*;

  localparam int unsigned ADDR_W    = (`RF_RV32E != 0) ? 4 : 5;
  localparam int unsigned NUM_WORDS = 2 ** ADDR_W;

  rf_data_t             mem [NUM_WORDS];
  rf_data_t             wdata_q;
  logic [NUM_WORDS-1:1] wen_d;
  logic [NUM_WORDS-1:1] wen_q;
  logic [ADDR_W-1:0]    raddr_a_int;
  logic [ADDR_W-1:0]    raddr_b_int;
  logic [ADDR_W-1:0]    waddr_int;

  // Upper index bit dropped for RV32E
  assign raddr_a_int = raddr_a_i[ADDR_W-1:0];
  assign raddr_b_int = raddr_b_i[ADDR_W-1:0];
  assign waddr_int   = waddr_i[ADDR_W-1:0];

  // Combinational reads
  assign rdata_a_o = mem[raddr_a_int];
  assign rdata_b_o = mem[raddr_b_int];

  // Write data captured on the enable cycle
  always_ff @(posedge clk_int) begin
    if (we_i) begin
      wdata_q <= wdata_i;
    end
  end

  // One-hot word enables, none for word 0
  always_comb begin
    for (int i = 1; i < NUM_WORDS; i++) begin
      wen_d[i] = we_i && (waddr_int == ADDR_W'(i));
    end
  end

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      wen_q <= '0;
    end else begin
      wen_q <= wen_d;
    end
  end

  // Commit a cycle after sampling
  // Word 0 cleared by reset and never enabled
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NUM_WORDS; i++) begin
        if (wen_q[i]) begin
          mem[i] <= wdata_q;
        end
      end
    end
  end

endmodule

//--- source/int_alu.sv
// --------------------
// Integer ALU
// Combinational arithmetic, logic, shifts and compare
// --------------------
`timescale 1ns/1ps

module int_alu (
  input  rf_types_pkg::alu_op_e  op_i,
  input  rf_types_pkg::rf_data_t a_i,
  input  rf_types_pkg::rf_data_t b_i,
  output rf_types_pkg::rf_data_t res_o
);

  import rf_types_pkg::*;

  logic [4:0] shamt;
  logic       lt;

  // Shift amount from the low five bits
  assign shamt = b_i[4:0];
  // Signed compare for SLT
  assign lt    = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      ALU_ADD: res_o = a_i + b_i;
      ALU_SUB: res_o = a_i - b_i;
      ALU_AND: res_o = a_i & b_i;
      ALU_OR:  res_o = a_i | b_i;
      ALU_XOR: res_o = a_i ^ b_i;
      ALU_SLL: res_o = a_i << shamt;
      // Logical shift, zero fill
      ALU_SRL: res_o = a_i >> shamt;
      ALU_SLT: res_o = rf_data_t'(lt);
      // LOADI and unused codes
      default: res_o = '0;
    endcase
  end

endmodule

//--- source/axil_types_pkg.sv
// --------------------
// AXI4-Lite port types
// Response codes and register map
// --------------------
`include "rf_cfg.svh"

package axil_types_pkg;

  // Only two responses are ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Byte offsets of the register map
  typedef enum logic [`AXIL_ADDR_W-1:0] {
    OFF_CMD    = 8'h00,
    OFF_IMM    = 8'h04,
    OFF_RESULT = 8'h08,
    OFF_STATUS = 8'h0C,
    // Register window, one word per index
    OFF_WIN    = 8'h80
  } reg_off_e;

endpackage

//--- source/rf_types_pkg.sv
// --------------------
// Register-file types
// Data word, register index and ALU opcodes
// --------------------
`include "rf_cfg.svh"

package rf_types_pkg;

  // One register word
  typedef logic [`RF_DATA_W-1:0] rf_data_t;

  // Register index, upper bit unused for RV32E
  typedef logic [4:0] rf_addr_t;

  // Opcode field of a CMD write
  typedef enum logic [3:0] {
    ALU_ADD   = 4'h0,
    ALU_SUB   = 4'h1,
    ALU_AND   = 4'h2,
    ALU_OR    = 4'h3,
    ALU_XOR   = 4'h4,
    ALU_SLL   = 4'h5,
    ALU_SRL   = 4'h6,
    ALU_SLT   = 4'h7,
    // Immediate straight into rd
    ALU_LOADI = 4'h8
  } alu_op_e;

endpackage

//--- source/rf_cfg.svh
// --------------------
// Register-file slice configuration
// Word width, register count and bus address width
// --------------------
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// Register and ALU word width
`define RF_DATA_W 32

// Set to 1 for the 16-register RV32E file
`define RF_RV32E 0

// Byte address width of the AXI4-Lite port
`define AXIL_ADDR_W 8

`endif
